// ==== rtl/boardLink_params.svh ====
`ifndef BOARDLINK_PARAMS_SVH
`define BOARDLINK_PARAMS_SVH

// board geometry
`define ROW_BITS 32 // data bits per board row
`define ROW_COUNT 8 // rows per board
`define INDEX_BITS 3 // row index width

// serial wire timing, in clk cycles per bit
`define BIT_PERIOD 4 // must be even

// index, row, then one even parity bit
`define WORD_BITS (`INDEX_BITS + `ROW_BITS + 1)

`endif

// ==== rtl/boardLinkPkg.sv ====
`include "boardLink_params.svh"

package boardLinkPkg;

	// one row of the board image
	typedef logic [`ROW_BITS-1:0] rowData;

	// names one of the board rows
	typedef logic [`INDEX_BITS-1:0] rowIndex;

	// one bit per row, set once that row has arrived
	typedef logic [`ROW_COUNT-1:0] rowMask;

	// counts 0 to WORD_BITS inclusive
	typedef logic [$clog2(`WORD_BITS + 1)-1:0] bitCount;

	// serializer FSM
	typedef enum logic [1:0] {
		idle, // waiting for a host row
		waitPeer, // row latched, peer not ready yet
		shift, // word on the wire
		gap // frame low for one bit period
	} serState;

endpackage

// ==== rtl/rowStreamIf.sv ====
`timescale 1ns/1ps

interface rowStreamIf import boardLinkPkg::*; ();

	logic valid;
	logic ready;
	rowData row;
	rowIndex index;
	logic parityError; // word failed the even parity check

	modport source (
		output valid, row, index, parityError,
		input ready
	);

	modport sink (
		input valid, row, index, parityError,
		output ready
	);

endinterface

// ==== rtl/boardSerializer.sv ====
`timescale 1ns/1ps
`include "boardLink_params.svh"

module boardSerializer import boardLinkPkg::*; (
	input logic clk,
	input logic arstN,
	input logic txValid,
	output logic txReady,
	input rowData txRow,
	input rowIndex txIndex,
	input logic peerReady,
	output logic sclkOut,
	output logic sdataOut,
	output logic sframeOut
);

	localparam int unsigned PHASE_BITS = $clog2(`BIT_PERIOD);
	localparam int unsigned HALF_PERIOD = `BIT_PERIOD / 2;

	serState state;
	logic [PHASE_BITS-1:0] phase; // clk cycle within the current bit
	bitCount bitsSent;
	logic [`WORD_BITS-1:0] shiftReg; // MSB is the bit on the wire
	logic [1:0] peerSync;
	logic accept;
	logic periodEnd;

	assign accept = txValid && txReady;
	assign periodEnd = (phase == PHASE_BITS'(`BIT_PERIOD - 1));

	assign txReady = (state == idle);
	assign sframeOut = (state == shift);
	assign sclkOut = sframeOut && (phase >= PHASE_BITS'(HALF_PERIOD)); // high in second half
	assign sdataOut = sframeOut && shiftReg[`WORD_BITS-1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			peerSync <= '0;
		end else begin
			peerSync <= {peerSync[0], peerReady}; // peer runs on its own clock
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			phase <= '0;
			bitsSent <= '0;
		end else begin
			case (state)
				idle: begin
					if (accept) begin
						state <= waitPeer;
					end
				end
				waitPeer: begin
					if (peerSync[1]) begin // frame rises next cycle
						state <= shift;
						phase <= '0;
						bitsSent <= '0;
					end
				end
				shift: begin
					if (periodEnd) begin
						phase <= '0;
						bitsSent <= bitsSent + 1'b1;
						if (bitsSent == bitCount'(`WORD_BITS - 1)) begin
							state <= gap; // last bit done
						end
					end else begin
						phase <= phase + 1'b1;
					end
				end
				gap: begin
					if (periodEnd) begin
						state <= idle;
						phase <= '0;
					end else begin
						phase <= phase + 1'b1;
					end
				end
			endcase
		end
	end

	// data moves only at the end of a period, when sclk drops low
	always_ff @(posedge clk) begin
		if (accept) begin
			shiftReg <= {txIndex, txRow, ^{txIndex, txRow}}; // even parity over the word
		end else if ((state == shift) && periodEnd) begin
			shiftReg <= {shiftReg[`WORD_BITS-2:0], 1'b0};
		end
	end

endmodule

// ==== rtl/boardDeserializer.sv ====
`timescale 1ns/1ps
`include "boardLink_params.svh"

module boardDeserializer import boardLinkPkg::*; (
	input logic clk,
	input logic arstN,
	input logic sclkIn,
	input logic sdataIn,
	input logic sframeIn,
	rowStreamIf.source rowOut,
	output logic busy
);

	logic [1:0] sclkSync;
	logic [1:0] dataSync;
	logic [1:0] frameSync;
	logic sclkPrev; // edge detect stage
	logic sclkRise;
	bitCount bitsIn;
	logic [`WORD_BITS-1:0] wordReg;
	logic wordDone;
	logic holdValid; // holding register full
	logic take;
	logic load;

	assign sclkRise = frameSync[1] && sclkSync[1] && !sclkPrev; // ignore sclk outside a frame
	assign wordDone = (bitsIn == bitCount'(`WORD_BITS));
	assign take = holdValid && rowOut.ready;
	assign load = wordDone && (!holdValid || take); // word is dropped on overrun

	assign rowOut.valid = holdValid;
	assign busy = holdValid;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sclkSync <= '0;
			dataSync <= '0;
			frameSync <= '0;
			sclkPrev <= 1'b0;
		end else begin
			sclkSync <= {sclkSync[0], sclkIn};
			dataSync <= {dataSync[0], sdataIn};
			frameSync <= {frameSync[0], sframeIn};
			sclkPrev <= sclkSync[1];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			bitsIn <= '0;
		end else if (!frameSync[1] || wordDone) begin
			bitsIn <= '0; // restart between frames
		end else if (sclkRise) begin
			bitsIn <= bitsIn + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (sclkRise) begin
			wordReg <= {wordReg[`WORD_BITS-2:0], dataSync[1]}; // MSB first
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			holdValid <= 1'b0;
		end else if (load) begin
			holdValid <= 1'b1;
		end else if (take) begin
			holdValid <= 1'b0;
		end
	end

	// fields stay put until the store takes the row
	always_ff @(posedge clk) begin
		if (load) begin
			rowOut.index <= wordReg[`WORD_BITS-1 -: `INDEX_BITS];
			rowOut.row <= wordReg[`ROW_BITS:1];
			rowOut.parityError <= ^wordReg; // nonzero means odd word
		end
	end

endmodule

// ==== rtl/boardStore.sv ====
`timescale 1ns/1ps
`include "boardLink_params.svh"

module boardStore import boardLinkPkg::*; (
	input logic clk,
	input logic arstN,
	rowStreamIf.sink rowIn,
	input logic rxHold,
	output logic rxRowValid,
	output rowData rxRow,
	output rowIndex rxIndex,
	output logic rxParityError,
	output logic frameComplete,
	input rowIndex readIndex,
	output rowData readRow
);

	rowData rows [`ROW_COUNT];
	rowMask mask;
	rowMask nextMask;
	logic take;
	logic goodTake; // take without parity error

	assign rowIn.ready = !rxHold;
	assign take = rowIn.valid && rowIn.ready;
	assign goodTake = take && !rowIn.parityError;
	assign nextMask = mask | (rowMask'(1) << rowIn.index);
	assign readRow = rows[readIndex];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rxRowValid <= 1'b0;
			frameComplete <= 1'b0;
			mask <= '0;
		end else begin
			rxRowValid <= take; // every row is reported, good or bad
			frameComplete <= 1'b0;
			if (goodTake) begin
				if (&nextMask) begin
					frameComplete <= 1'b1; // whole board arrived
					mask <= '0;
				end else begin
					mask <= nextMask;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rxRow <= rowIn.row;
			rxIndex <= rowIn.index;
			rxParityError <= rowIn.parityError;
		end
	end

	// board image reads as all zero until rows arrive
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `ROW_COUNT; i++) begin
				rows[i] <= '0;
			end
		end else if (goodTake) begin
			rows[rowIn.index] <= rowIn.row;
		end
	end

endmodule

// ==== rtl/boardLink.sv ====
`timescale 1ns/1ps

module boardLink import boardLinkPkg::*; (
	input logic clk,
	input logic arstN,
	input logic txValid,
	output logic txReady,
	input rowData txRow,
	input rowIndex txIndex,
	input logic peerReady,
	output logic sclkOut,
	output logic sdataOut,
	output logic sframeOut,
	input logic sclkIn,
	input logic sdataIn,
	input logic sframeIn,
	output logic localReady,
	input logic rxHold,
	output logic rxRowValid,
	output rowData rxRow,
	output rowIndex rxIndex,
	output logic rxParityError,
	output logic frameComplete,
	input rowIndex readIndex,
	output rowData readRow
);

	rowStreamIf rowLink ();
	logic deserBusy;

	boardSerializer serializer (
		.clk(clk),
		.arstN(arstN),
		.txValid(txValid),
		.txReady(txReady),
		.txRow(txRow),
		.txIndex(txIndex),
		.peerReady(peerReady),
		.sclkOut(sclkOut),
		.sdataOut(sdataOut),
		.sframeOut(sframeOut)
	);

	boardDeserializer deserializer (
		.clk(clk),
		.arstN(arstN),
		.sclkIn(sclkIn),
		.sdataIn(sdataIn),
		.sframeIn(sframeIn),
		.rowOut(rowLink.source),
		.busy(deserBusy)
	);

	boardStore store (
		.clk(clk),
		.arstN(arstN),
		.rowIn(rowLink.sink),
		.rxHold(rxHold),
		.rxRowValid(rxRowValid),
		.rxRow(rxRow),
		.rxIndex(rxIndex),
		.rxParityError(rxParityError),
		.frameComplete(frameComplete),
		.readIndex(readIndex),
		.readRow(readRow)
	);

	// tell the peer to wait while a row is parked or the host holds off
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			localReady <= 1'b0;
		end else begin
			localReady <= !deserBusy && !rxHold;
		end
	end

endmodule

// ==== verification/boardLink_assert.sv ====
`timescale 1ns/1ps

module boardLinkAssert import boardLinkPkg::*; (
	input logic clk,
	input logic arstN,
	input logic sclkOut,
	input logic sdataOut,
	input logic txValid,
	input logic txReady,
	input rowData txRow,
	input logic rxRowValid,
	input logic frameComplete
);

	int unsigned failCount = 0; // summed into the testbench error count

	// the receiver samples on the rising sclk edge
	serialDataStable: assert property (@(posedge clk) disable iff (!arstN)
		sclkOut |-> $stable(sdataOut))
	else begin
		$error("sdataOut changed while sclkOut was high");
		failCount++;
	end

	txRowHeld: assert property (@(posedge clk) disable iff (!arstN)
		txValid && !txReady |=> $stable(txRow))
	else begin
		$error("txRow changed while the row waited for txReady");
		failCount++;
	end

	frameWithRow: assert property (@(posedge clk) disable iff (!arstN)
		frameComplete |-> rxRowValid)
	else begin
		$error("frameComplete pulsed without a row report");
		failCount++;
	end

endmodule

bind boardLink boardLinkAssert checks (
	.clk(clk),
	.arstN(arstN),
	.sclkOut(sclkOut),
	.sdataOut(sdataOut),
	.txValid(txValid),
	.txReady(txReady),
	.txRow(txRow),
	.rxRowValid(rxRowValid),
	.frameComplete(frameComplete)
);

// ==== verification/boardLinkTb.sv ====
`timescale 1ns/1ps
`include "boardLink_params.svh"

module boardLinkTb import boardLinkPkg::*; ();

	localparam int TIMEOUT = 1000; // cycles allowed per wait
	localparam int WORD_CYCLES = `WORD_BITS * `BIT_PERIOD;

	logic clk;
	logic arstN;
	logic txValid;
	logic txReady;
	rowData txRow;
	rowIndex txIndex;
	logic peerReady = 1'b0;
	logic sclkOut;
	logic sdataOut;
	logic sframeOut;
	logic sclkIn = 1'b0;
	logic sdataIn = 1'b0;
	logic sframeIn = 1'b0;
	logic localReady;
	logic rxHold = 1'b0;
	logic rxRowValid;
	rowData rxRow;
	rowIndex rxIndex;
	logic rxParityError;
	logic frameComplete;
	rowIndex readIndex;
	rowData readRow;

	rowData expRow[$]; // rows in the order they should arrive
	rowIndex expIndex[$];
	logic expErr[$];
	int flipQ[$]; // wire bit to corrupt in each word or -1
	rowData modelRows[`ROW_COUNT];
	rowMask modelMask = '0;
	rowMask newMask;
	logic expFrame;
	logic [15:0] stimLfsr = 16'd4;
	logic [15:0] holdLfsr = 16'd4;
	logic [31:0] holdDraw;
	logic holdEnable = 1'b0;
	logic aborted = 1'b0;
	logic txBusy = 1'b0; // row accepted and gap not yet over
	logic wordDone = 1'b0;
	logic framePrev = 1'b0;
	int holdLeft = 0;
	int flipBit = -1;
	int wireCycle = 0;
	int frameLen = 0;
	int gapLen = 0;
	int sinceReady = 0; // negedges since localReady was last high
	int framesSeen = 0;
	int mismatchCount = 0;
	int otherCount = 0;

	boardLink UUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// 16 bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(inout logic [15:0] state, input int count,
			output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			state = lfsrStep(state);
			value = {value[30:0], state[0]};
		end
	endtask

	task automatic reportMismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		mismatchCount++;
		$display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic reportFailure(input string what);
		otherCount++;
		$display("Error at %0d ns: %s", $time, what);
	endtask

	// loopback wire flipping one data bit on words that ask for it
	always @(posedge clk) begin
		sclkIn <= sclkOut;
		sframeIn <= sframeOut;
		peerReady <= localReady;
		if (sframeOut) begin
			if (wireCycle == 0) begin
				assert (flipQ.size() > 0)
					else reportFailure("a word went out that was never accepted");
				flipBit = (flipQ.size() > 0) ? flipQ.pop_front() : -1;
			end
			sdataIn <= sdataOut ^ (flipBit == wireCycle / `BIT_PERIOD);
			wireCycle <= wireCycle + 1;
		end else begin
			sdataIn <= sdataOut;
			wireCycle <= 0;
		end
	end

	// rxHold in random bursts of 1 to 32 cycles
	always @(posedge clk) begin
		if (!holdEnable) begin
			rxHold <= 1'b0;
			holdLeft <= 0;
		end else if (holdLeft == 0) begin
			drawBits(holdLfsr, 5, holdDraw);
			rxHold <= !rxHold;
			holdLeft <= int'(holdDraw) + 1;
		end else begin
			holdLeft <= holdLeft - 1;
		end
	end

	always @(negedge clk) begin
		if (frameComplete) framesSeen++;
		if (rxRowValid && expRow.size() == 0) begin
			reportFailure("a row arrived that was never sent");
		end else if (rxRowValid) begin
			assert (rxIndex == expIndex[0]) else reportMismatch("rxIndex", rxIndex, expIndex[0]);
			assert (rxRow == expRow[0]) else reportMismatch("rxRow", rxRow, expRow[0]);
			assert (rxParityError == expErr[0])
				else reportMismatch("rxParityError", rxParityError, expErr[0]);
			newMask = modelMask;
			newMask[expIndex[0]] = 1'b1;
			expFrame = !expErr[0] && (&newMask); // bad rows leave the mask alone
			if (!expErr[0]) begin
				modelRows[expIndex[0]] = expRow[0];
				modelMask = expFrame ? '0 : newMask;
			end
			assert (frameComplete == expFrame)
				else reportMismatch("frameComplete", frameComplete, expFrame);
			void'(expRow.pop_front());
			void'(expIndex.pop_front());
			void'(expErr.pop_front());
		end else begin
			assert (!frameComplete) else reportFailure("frameComplete pulsed without a row");
		end

		if (sframeOut) begin
			frameLen++;
		end else if (frameLen != 0) begin
			assert (frameLen == WORD_CYCLES)
				else reportMismatch("frame length", frameLen, WORD_CYCLES);
			frameLen = 0;
			wordDone = txBusy;
		end
		if (txBusy && txReady) begin
			assert (wordDone && gapLen == `BIT_PERIOD)
				else reportFailure("txReady came back before the word and its gap ended");
			txBusy = 1'b0;
		end else if (txBusy && wordDone) begin
			gapLen++;
		end
		if (!txBusy && txValid && txReady) begin // accepted on the next edge
			txBusy = 1'b1;
			wordDone = 1'b0;
			gapLen = 0;
		end

		// two synchronizer stages plus the loopback register
		if (sframeOut && !framePrev) begin
			assert (sinceReady <= 4)
				else reportFailure("a word started while the receiver held off");
		end
		framePrev = sframeOut;
		sinceReady = localReady ? 0 : sinceReady + 1;
	end

	// flip picks the wire bit to corrupt and 3 to 34 lands in the row field
	task automatic sendRow(input rowIndex idx, input rowData row, input int flip);
		int waitCycles;
		if (aborted) return;
		@(posedge clk);
		txValid <= 1'b1;
		txIndex <= idx;
		txRow <= row;
		waitCycles = 0;
		@(negedge clk);
		while (!txReady && waitCycles < TIMEOUT) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!txReady) begin
			reportFailure("the serializer never accepted a row");
			aborted = 1'b1;
			return;
		end
		@(posedge clk);
		txValid <= 1'b0;
		expRow.push_back((flip < 0) ? row : row ^ (rowData'(1) << (`WORD_BITS - 2 - flip)));
		expIndex.push_back(idx);
		expErr.push_back(flip >= 0);
		flipQ.push_back(flip);
	endtask

	task automatic sendRandomBoard();
		rowIndex order[`ROW_COUNT];
		rowIndex swap;
		logic [31:0] r;
		int j;
		for (int i = 0; i < `ROW_COUNT; i++) order[i] = rowIndex'(i);
		for (int i = `ROW_COUNT - 1; i > 0; i--) begin // shuffle
			drawBits(stimLfsr, 8, r);
			j = int'(r) % (i + 1);
			swap = order[i];
			order[i] = order[j];
			order[j] = swap;
		end
		for (int i = 0; i < `ROW_COUNT; i++) begin
			drawBits(stimLfsr, `ROW_BITS, r);
			sendRow(order[i], rowData'(r), -1);
		end
	endtask

	task automatic sendRandomRows(input int count);
		logic [31:0] idx;
		logic [31:0] row;
		logic [31:0] r;
		int flip;
		for (int k = 0; k < count; k++) begin
			drawBits(stimLfsr, `INDEX_BITS, idx);
			drawBits(stimLfsr, `ROW_BITS, row);
			drawBits(stimLfsr, 3, r);
			flip = -1;
			if (r == 0) begin // about one word in eight
				drawBits(stimLfsr, 5, r);
				flip = 3 + int'(r);
			end
			sendRow(rowIndex'(idx), rowData'(row), flip);
		end
	endtask

	task automatic drainRows();
		int waitCycles;
		if (aborted) return;
		waitCycles = 0;
		while (expRow.size() != 0 && waitCycles < 2 * TIMEOUT) begin
			@(negedge clk);
			waitCycles++;
		end
		if (expRow.size() != 0) begin
			reportFailure("sent rows never arrived at the store");
			aborted = 1'b1;
		end
	endtask

	task automatic checkReadBack();
		if (aborted) return;
		for (int i = 0; i < `ROW_COUNT; i++) begin
			@(posedge clk);
			readIndex <= rowIndex'(i);
			@(negedge clk);
			assert (readRow == modelRows[i])
				else reportMismatch("readRow", readRow, modelRows[i]);
		end
	endtask

	initial begin
		arstN = 1'b0;
		txValid = 1'b0;
		txRow = '0;
		txIndex = '0;
		readIndex = '0;
		for (int i = 0; i < `ROW_COUNT; i++) modelRows[i] = '0;
		repeat (9) @(posedge clk);
		@(negedge clk);
		assert (txReady) else reportMismatch("txReady in reset", txReady, 1);
		assert ({sclkOut, sdataOut, sframeOut, localReady, rxRowValid, frameComplete} == 6'b0)
			else reportMismatch("control outputs in reset",
				{sclkOut, sdataOut, sframeOut, localReady, rxRowValid, frameComplete}, 0);
		@(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		assert (localReady) else reportMismatch("localReady after reset", localReady, 1);

		sendRandomBoard();
		drainRows();
		assert (framesSeen == 1) else reportMismatch("completed boards", framesSeen, 1);
		checkReadBack();

		@(posedge clk);
		holdEnable <= 1'b1;
		sendRandomRows(40);
		drainRows();
		@(posedge clk);
		holdEnable <= 1'b0;
		checkReadBack();

		otherCount += int'(UUT.checks.failCount);
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/boardLinkPkg.sv
rtl/rowStreamIf.sv
rtl/boardSerializer.sv
rtl/boardDeserializer.sv
rtl/boardStore.sv
rtl/boardLink.sv
verification/boardLink_assert.sv
verification/boardLinkTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the loopback testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f list.f --top-module boardLinkTb -o boardLinkSim
result=$(./obj_dir/boardLinkSim +verilator+error+limit+100)
echo "$result"
echo "$result" | grep -qx "SIMULATION PASSED"
